// ==== praxos.f ====
+incdir+.
praxos_isa_pkg.sv
praxos_bus_pkg.sv
praxos_ctrl.sv
praxos_pm.sv
praxos_core.sv
praxos_top.sv
praxos_checker.sv
praxos_properties.sv
tb_praxos.sv

// ==== Bender.yml ====
package:
  name: praxos

export_include_dirs:
  - .

sources:
  - praxos_isa_pkg.sv
  - praxos_bus_pkg.sv
  - praxos_ctrl.sv
  - praxos_pm.sv
  - praxos_core.sv
  - praxos_top.sv
  - target: test
    files:
      - praxos_checker.sv
      - praxos_properties.sv
      - tb_praxos.sv

// ==== tb_praxos.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "praxos_defs.svh"

module tb_praxos;
    import praxos_bus_pkg::*;
    import praxos_isa_pkg::*;

    localparam int ACK_LIMIT  = 32;
    localparam int POLL_LIMIT = 400;

    typedef enum logic [2:0] {K_WR, K_RD, K_POLL, K_IRQ_IN, K_IRQ_OUT, K_END} row_kind_e;

    typedef struct packed {
        row_kind_e  kind;
        port_addr_t adr;
        word_t      data;
        word_t      exp;
    } row_t;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    word_t   irq_i;
    logic    irq_o;
    logic    rd_chk;
    word_t   rd_exp;
    logic    irq_chk;
    logic    irq_exp;
    logic    stall_exp;
    row_t    rows[$];
    string   test_names[$];
    integer  seed;
    word_t   gp[16];
    word_t   rdata;
    word_t   acc;
    word_t   mask;
    word_t   count;
    int      prop_fails;

    praxos_top praxos_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .irq_i    (irq_i),
        .irq_o    (irq_o)
    );

    praxos_checker praxos_checker_i (
        .clk         (clk),
        .wb_req_i    (wb_req),
        .wb_rsp_i    (wb_rsp),
        .irq_out_i   (irq_o),
        .rd_chk_i    (rd_chk),
        .rd_exp_i    (rd_exp),
        .irq_chk_i   (irq_chk),
        .irq_exp_i   (irq_exp),
        .stall_exp_i (stall_exp)
    );

    always #5 clk = ~clk;

    // Instruction layout: opcode 35..32, port 31..26, immediate 25..0
    function automatic instr_t encode_instr(opcode_e op, port_addr_t port, word_t imm);
        return {op, port, imm[25:0]};
    endfunction

    task automatic push_row(row_kind_e kind, port_addr_t adr, word_t data, word_t exp);
        row_t r;
        r.kind = kind;
        r.adr  = adr;
        r.data = data;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    task automatic load_word(int addr, opcode_e op, port_addr_t port, word_t imm);
        instr_t ins;
        ins = encode_instr(op, port, imm);
        push_row(K_WR, `PRAXOS_REG_PM_LO, ins[31:0], '0);
        push_row(K_WR, `PRAXOS_REG_PM_HI, word_t'(ins[35:32]), '0);
        push_row(K_WR, `PRAXOS_REG_PM_ADDR, word_t'(addr), '0);
    endtask

    // Pulse the run bit low so the core restarts from address 0
    task automatic run_program();
        push_row(K_WR, `PRAXOS_REG_CTRL, 32'd0, '0);
        push_row(K_WR, `PRAXOS_REG_CTRL, 32'd1, '0);
        push_row(K_POLL, `PRAXOS_REG_CTRL, '0, '0);
        push_row(K_RD, `PRAXOS_REG_CTRL, '0, 32'd3);
    endtask

    task automatic end_test(string name);
        test_names.push_back(name);
        push_row(K_END, '0, word_t'(test_names.size() - 1), '0);
    endtask

    task automatic wb_cycle(input logic we, input port_addr_t adr, input word_t dat,
                            input logic chk, input word_t exp, output word_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = dat;
        wb_req.sel   = 4'hf;
        rd_chk       = chk;
        rd_exp       = exp;
        // Stall holds until the ack cycle
        stall_exp    = 1'b1;
        @(negedge clk);
        stall_exp = 1'b0;
        while (!wb_rsp.ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        data = wb_rsp.dat_r;
        if (!wb_rsp.ack) begin
            praxos_checker_i.note_failure(
                $sformatf("no Wishbone ack from address %0d", adr));
        end
        // Keep cyc for the ack cycle so the checker sees it
        wb_req.stb = 1'b0;
        @(negedge clk);
        wb_req.cyc = 1'b0;
        rd_chk     = 1'b0;
    endtask

    task automatic poll_halted();
        int polls;
        word_t data;
        polls = 0;
        data  = '0;
        while (!data[1] && polls < POLL_LIMIT) begin
            wb_cycle(1'b0, `PRAXOS_REG_CTRL, '0, 1'b0, '0, data);
            polls++;
        end
        if (!data[1]) begin
            praxos_checker_i.note_failure("core did not reach HALT in time");
        end
    endtask

    task automatic check_irq(logic level);
        @(negedge clk);
        irq_chk = 1'b1;
        irq_exp = level;
        @(negedge clk);
        irq_chk = 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        wb_req    = '0;
        irq_i     = '0;
        rd_chk    = 1'b0;
        rd_exp    = '0;
        irq_chk   = 1'b0;
        irq_exp   = 1'b0;
        stall_exp = 1'b0;
        seed      = 32'h5a40ad22;

        push_row(K_RD, `PRAXOS_REG_CTRL, '0, '0);
        push_row(K_RD, `PRAXOS_REG_IRQ, '0, '0);
        push_row(K_IRQ_OUT, '0, '0, '0);
        end_test("reset values");

        for (int i = 0; i < 16; i++) begin
            gp[i] = $random(seed);
            push_row(K_WR, port_addr_t'(16 + i), gp[i], '0);
        end
        for (int i = 0; i < 16; i++) begin
            push_row(K_RD, port_addr_t'(16 + i), '0, gp[i]);
        end
        push_row(K_RD, 6'd6, '0, '0);
        push_row(K_RD, 6'd15, '0, '0);
        push_row(K_RD, 6'd32, '0, '0);
        push_row(K_RD, 6'd63, '0, '0);
        end_test("register access");

        // Straight-line LDI/ADDI/OUT with random 26-bit immediates
        gp[0] = $random(seed) & 32'h03ff_ffff;
        gp[1] = $random(seed) & 32'h03ff_ffff;
        gp[2] = $random(seed) & 32'h03ff_ffff;
        load_word(0, OP_LDI, 0, gp[0]);
        load_word(1, OP_OUT, 16, '0);
        load_word(2, OP_ADDI, 0, gp[1]);
        load_word(3, OP_OUT, 17, '0);
        load_word(4, OP_ADDI, 0, gp[2]);
        load_word(5, OP_OUT, 18, '0);
        load_word(6, OP_HALT, 0, '0);
        run_program();
        acc = gp[0];
        push_row(K_RD, 6'd16, '0, acc);
        acc = acc + gp[1];
        push_row(K_RD, 6'd17, '0, acc);
        acc = acc + gp[2];
        push_row(K_RD, 6'd18, '0, acc);
        end_test("program execution");

        // Register 22 starts at minus count and is stepped up to zero
        count = ($random(seed) & 32'd7) + 32'd3;
        push_row(K_WR, 6'd22, 32'd0 - count, '0);
        load_word(0, OP_LDI, 0, '0);
        load_word(1, OP_OUT, 21, '0);
        load_word(2, OP_IN, 22, '0);
        load_word(3, OP_ADDI, 0, 32'd1);
        load_word(4, OP_OUT, 22, '0);
        load_word(5, OP_IN, 21, '0);
        load_word(6, OP_ADDI, 0, 32'd1);
        load_word(7, OP_OUT, 21, '0);
        load_word(8, OP_IN, 22, '0);
        load_word(9, OP_JNZ, 0, 32'd3);
        load_word(10, OP_HALT, 0, '0);
        run_program();
        push_row(K_RD, 6'd21, '0, count);
        push_row(K_RD, 6'd22, '0, '0);
        end_test("loop and branch");

        mask = ($random(seed) & 32'h03ff_ffff) | 32'h0101_0001;
        load_word(0, OP_LDI, 0, mask);
        load_word(1, OP_OUT, 0, '0);
        load_word(2, OP_HALT, 0, '0);
        run_program();
        push_row(K_IRQ_OUT, '0, '0, 32'd1);
        push_row(K_RD, `PRAXOS_REG_IRQ, '0, mask);
        push_row(K_WR, `PRAXOS_REG_IRQ, mask & 32'h0000_ffff, '0);
        push_row(K_RD, `PRAXOS_REG_IRQ, '0, mask & 32'hffff_0000);
        push_row(K_IRQ_OUT, '0, '0, 32'd1);
        push_row(K_WR, `PRAXOS_REG_IRQ, 32'hffff_ffff, '0);
        push_row(K_RD, `PRAXOS_REG_IRQ, '0, '0);
        push_row(K_IRQ_OUT, '0, '0, '0);
        end_test("interrupts");

        gp[3] = $random(seed);
        push_row(K_IRQ_IN, '0, gp[3], '0);
        push_row(K_RD, `PRAXOS_REG_IRQ_IN, '0, gp[3]);
        load_word(0, OP_IN, 1, '0);
        load_word(1, OP_OUT, 20, '0);
        load_word(2, OP_HALT, 0, '0);
        run_program();
        push_row(K_RD, 6'd20, '0, gp[3]);
        end_test("interrupt input");

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        foreach (rows[i]) begin
            case (rows[i].kind)
                K_WR:      wb_cycle(1'b1, rows[i].adr, rows[i].data, 1'b0, '0, rdata);
                K_RD:      wb_cycle(1'b0, rows[i].adr, '0, 1'b1, rows[i].exp, rdata);
                K_POLL:    poll_halted();
                K_IRQ_IN: begin
                    @(negedge clk);
                    irq_i = rows[i].data;
                    // Sampling register lags by a clock
                    @(negedge clk);
                end
                K_IRQ_OUT: check_irq(rows[i].exp[0]);
                default:   praxos_checker_i.finish_test(test_names[rows[i].data]);
            endcase
        end

        prop_fails = praxos_top_i.praxos_ctrl_i.praxos_properties_i.fail_count;
        praxos_checker_i.print_counts(prop_fails);
        if (praxos_checker_i.errors == 0 && prop_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== praxos_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module praxos_properties (
    input wire                          clk,
    input wire                          rst_n,
    input wire praxos_bus_pkg::wb_req_t wb_req_i,
    input wire praxos_bus_pkg::wb_rsp_t wb_rsp_i,
    input wire praxos_bus_pkg::pm_wr_t  pm_wr_i
);
    int fail_count = 0;

    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req_i.cyc && wb_req_i.stb) |=> wb_rsp_i.ack)
    else begin
        fail_count++;
        $error("ack did not follow stb by one cycle");
    end

    ack_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp_i.ack |-> wb_req_i.cyc)
    else begin
        fail_count++;
        $error("ack seen without cyc");
    end

    // Program write strobe lasts one clock
    pm_wr_single: assert property (@(posedge clk) disable iff (!rst_n)
        pm_wr_i.wr |=> !pm_wr_i.wr)
    else begin
        fail_count++;
        $error("program write held for more than one cycle");
    end

    err_low: assert property (@(posedge clk) disable iff (!rst_n)
        !wb_rsp_i.err)
    else begin
        fail_count++;
        $error("Wishbone err went high");
    end

endmodule

bind praxos_ctrl praxos_properties praxos_properties_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req_i (wb_req_i),
    .wb_rsp_i (wb_rsp_o),
    .pm_wr_i  (pm_wr_o)
);

`default_nettype wire

// ==== praxos_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module praxos_checker (
    input wire                          clk,
    input wire praxos_bus_pkg::wb_req_t wb_req_i,
    input wire praxos_bus_pkg::wb_rsp_t wb_rsp_i,
    input wire                          irq_out_i,
    input wire                          rd_chk_i,
    input wire praxos_isa_pkg::word_t   rd_exp_i,
    input wire                          irq_chk_i,
    input wire                          irq_exp_i,
    input wire                          stall_exp_i
);
    import praxos_isa_pkg::*;

    int tests = 0;
    int checks = 0;
    int errors = 0;
    int test_checks = 0;
    int test_errors = 0;

    // Sampled at the rising edge, before registers update
    always @(posedge clk) begin
        if (rd_chk_i && wb_req_i.cyc && !wb_req_i.we && wb_rsp_i.ack) begin
            checks++;
            test_checks++;
            if (wb_rsp_i.dat_r !== rd_exp_i) begin
                errors++;
                test_errors++;
                $display("** Error at %0t: wb_rsp_o.dat_r (address %0d) is %h, expected %h",
                         $time, wb_req_i.adr, wb_rsp_i.dat_r, rd_exp_i);
            end
        end
        if (wb_req_i.cyc) begin
            checks++;
            test_checks++;
            if (wb_rsp_i.stall !== stall_exp_i) begin
                errors++;
                test_errors++;
                $display("** Error at %0t: wb_rsp_o.stall is %b, expected %b",
                         $time, wb_rsp_i.stall, stall_exp_i);
            end
        end
        if (irq_chk_i) begin
            checks++;
            test_checks++;
            if (irq_out_i !== irq_exp_i) begin
                errors++;
                test_errors++;
                $display("** Error at %0t: irq_o is %b, expected %b",
                         $time, irq_out_i, irq_exp_i);
            end
        end
    end

    task automatic note_failure(string what);
        errors++;
        test_errors++;
        $display("** Failure at %0t: %s", $time, what);
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("Test %0d %s: %s, %0d checks, %0d failed", tests, name,
                 (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic print_counts(int assert_fails);
        $display("%0d tests, %0d checks, %0d mismatches or timeouts, %0d assertion failures",
                 tests, checks, errors, assert_fails);
    endtask

endmodule

`default_nettype wire

// ==== praxos_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module praxos_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire praxos_bus_pkg::wb_req_t wb_req_i,
    output praxos_bus_pkg::wb_rsp_t      wb_rsp_o,
    input  wire praxos_isa_pkg::word_t   irq_i,
    output logic                         irq_o
);
    import praxos_bus_pkg::*;
    import praxos_isa_pkg::*;

    pm_wr_t    pm_wr;
    pm_addr_t  pm_rd_addr;
    instr_t    pm_rd_data;
    port_req_t port_req;
    word_t     port_rd_data;
    logic      core_rst_n;
    logic      core_halted;

    praxos_ctrl praxos_ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_req_i       (wb_req_i),
        .wb_rsp_o       (wb_rsp_o),
        .irq_i          (irq_i),
        .irq_o          (irq_o),
        .pm_wr_o        (pm_wr),
        .core_rst_n_o   (core_rst_n),
        .core_halted_i  (core_halted),
        .port_req_i     (port_req),
        .port_rd_data_o (port_rd_data)
    );

    praxos_pm praxos_pm_i (
        .clk       (clk),
        .wr_i      (pm_wr),
        .rd_addr_i (pm_rd_addr),
        .rd_data_o (pm_rd_data)
    );

    praxos_core praxos_core_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_rst_n_i   (core_rst_n),
        .pm_rd_addr_o   (pm_rd_addr),
        .pm_rd_data_i   (pm_rd_data),
        .port_req_o     (port_req),
        .port_rd_data_i (port_rd_data),
        .halted_o       (core_halted)
    );

endmodule

`default_nettype wire

// ==== praxos_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module praxos_core (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           core_rst_n_i,
    output praxos_isa_pkg::pm_addr_t      pm_rd_addr_o,
    input  wire praxos_isa_pkg::instr_t   pm_rd_data_i,
    output praxos_bus_pkg::port_req_t     port_req_o,
    input  wire praxos_isa_pkg::word_t    port_rd_data_i,
    output logic                          halted_o
);
    import praxos_isa_pkg::*;

    core_state_e   state_q;
    pm_addr_t      pc_q;
    word_t         acc_q;
    instr_fields_t ir;
    logic          exec;

    // Fetched word arrives one clock after the address
    assign ir           = pm_rd_data_i;
    assign exec         = state_q == ST_EXEC;
    assign pm_rd_addr_o = pc_q;
    assign halted_o     = state_q == ST_HALTED;

    always_comb begin
        port_req_o.rd      = exec && ir.op == OP_IN;
        port_req_o.wr      = exec && ir.op == OP_OUT;
        port_req_o.addr    = ir.port;
        port_req_o.wr_data = acc_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !core_rst_n_i) begin
            state_q <= ST_FETCH;
            pc_q    <= '0;
            acc_q   <= '0;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    state_q <= ST_EXEC;
                end
                ST_EXEC: begin
                    state_q <= ST_FETCH;
                    pc_q    <= pc_q + 1'b1;
                    case (ir.op)
                        OP_LDI: begin
                            acc_q <= word_t'(ir.imm);
                        end
                        OP_ADDI: begin
                            acc_q <= acc_q + word_t'(ir.imm);
                        end
                        OP_IN: begin
                            acc_q <= port_rd_data_i;
                        end
                        OP_JMP: begin
                            pc_q <= pm_addr_t'(ir.imm);
                        end
                        OP_JNZ: begin
                            if (acc_q != '0) begin
                                pc_q <= pm_addr_t'(ir.imm);
                            end
                        end
                        OP_HALT: begin
                            state_q <= ST_HALTED;
                        end
                        // NOP, OUT and unused codes
                        default: ;
                    endcase
                end
                // Halted until the host drops the run bit
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== praxos_pm.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "praxos_defs.svh"

module praxos_pm (
    input  wire                           clk,
    input  wire praxos_bus_pkg::pm_wr_t   wr_i,
    input  wire praxos_isa_pkg::pm_addr_t rd_addr_i,
    output praxos_isa_pkg::instr_t        rd_data_o
);
    import praxos_isa_pkg::*;

    instr_t mem_q [`PRAXOS_PM_DEPTH];

    // One write port from the host, one read port for fetch
    always_ff @(posedge clk) begin
        if (wr_i.wr) begin
            mem_q[wr_i.addr] <= wr_i.data;
        end
        rd_data_o <= mem_q[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== praxos_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "praxos_defs.svh"

module praxos_ctrl (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire praxos_bus_pkg::wb_req_t   wb_req_i,
    output praxos_bus_pkg::wb_rsp_t        wb_rsp_o,
    input  wire praxos_isa_pkg::word_t     irq_i,
    output logic                           irq_o,
    output praxos_bus_pkg::pm_wr_t         pm_wr_o,
    output logic                           core_rst_n_o,
    input  wire                            core_halted_i,
    input  wire praxos_bus_pkg::port_req_t port_req_i,
    output praxos_isa_pkg::word_t          port_rd_data_o
);
    import praxos_isa_pkg::*;

    word_t    gp_q [`PRAXOS_GP_NUM];
    word_t    irq_q;
    word_t    irq_d;
    word_t    irq_in_q;
    word_t    wb_rd_q;
    word_t    wb_rd_d;
    instr_t   pm_data_q;
    pm_addr_t pm_addr_q;
    logic     pm_wr_q;
    logic     run_q;
    logic     ack_q;
    logic     wb_req;
    logic     wb_wr;
    logic     wb_rd;

    function automatic logic is_gp(port_addr_t addr);
        return (addr >= `PRAXOS_REG_GP_BASE) &&
               (addr < `PRAXOS_REG_GP_BASE + `PRAXOS_GP_NUM);
    endfunction

    assign wb_req = wb_req_i.cyc & wb_req_i.stb;
    assign wb_wr  = wb_req & wb_req_i.we;
    assign wb_rd  = wb_req & ~wb_req_i.we;

    always_comb begin
        wb_rsp_o.dat_r = wb_rd_q;
        wb_rsp_o.ack   = ack_q & wb_req_i.cyc;
        wb_rsp_o.stall = wb_req_i.cyc & ~(ack_q & wb_req_i.cyc);
        wb_rsp_o.err   = 1'b0;
    end

    assign irq_o        = |irq_q;
    assign core_rst_n_o = run_q;

    always_comb begin
        pm_wr_o.wr   = pm_wr_q;
        pm_wr_o.addr = pm_addr_q;
        pm_wr_o.data = pm_data_q;
    end

    always_comb begin
        irq_d = irq_q;
        if (wb_wr && wb_req_i.adr == `PRAXOS_REG_IRQ) begin
            irq_d = irq_d & ~wb_req_i.dat_w;
        end
        // Core set beats host clear on the same bit
        if (port_req_i.wr && port_req_i.addr == `PRAXOS_REG_IRQ) begin
            irq_d = irq_d | port_req_i.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            pm_wr_q  <= 1'b0;
            run_q    <= 1'b0;
            irq_q    <= '0;
            irq_in_q <= '0;
        end else begin
            ack_q    <= wb_req;
            irq_q    <= irq_d;
            irq_in_q <= irq_i;
            // Writing the address register issues the program write
            pm_wr_q  <= wb_wr && wb_req_i.adr == `PRAXOS_REG_PM_ADDR;
            if (wb_wr && wb_req_i.adr == `PRAXOS_REG_CTRL) begin
                run_q <= wb_req_i.dat_w[0];
            end
        end
    end

    // Program staging and read data
    always_ff @(posedge clk) begin
        if (wb_wr) begin
            case (wb_req_i.adr)
                `PRAXOS_REG_PM_LO:   pm_data_q[31:0]  <= wb_req_i.dat_w;
                `PRAXOS_REG_PM_HI:   pm_data_q[35:32] <= wb_req_i.dat_w[3:0];
                `PRAXOS_REG_PM_ADDR: pm_addr_q        <= pm_addr_t'(wb_req_i.dat_w);
                default: ;
            endcase
        end
        if (wb_rd) begin
            wb_rd_q <= wb_rd_d;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_wr && is_gp(wb_req_i.adr)) begin
            gp_q[wb_req_i.adr[3:0]] <= wb_req_i.dat_w;
        end
        // Port write last so it wins a conflict
        if (port_req_i.wr && is_gp(port_req_i.addr)) begin
            gp_q[port_req_i.addr[3:0]] <= port_req_i.wr_data;
        end
    end

    always_comb begin
        wb_rd_d = '0;
        if (is_gp(wb_req_i.adr)) begin
            wb_rd_d = gp_q[wb_req_i.adr[3:0]];
        end else begin
            case (wb_req_i.adr)
                `PRAXOS_REG_IRQ:     wb_rd_d = irq_q;
                `PRAXOS_REG_IRQ_IN:  wb_rd_d = irq_in_q;
                `PRAXOS_REG_PM_LO:   wb_rd_d = pm_data_q[31:0];
                `PRAXOS_REG_PM_HI:   wb_rd_d = word_t'(pm_data_q[35:32]);
                `PRAXOS_REG_PM_ADDR: wb_rd_d = word_t'(pm_addr_q);
                `PRAXOS_REG_CTRL:    wb_rd_d = {30'd0, core_halted_i, run_q};
                default: ;
            endcase
        end
    end

    always_comb begin
        port_rd_data_o = '0;
        if (port_req_i.rd) begin
            if (is_gp(port_req_i.addr)) begin
                port_rd_data_o = gp_q[port_req_i.addr[3:0]];
            end else if (port_req_i.addr == `PRAXOS_REG_IRQ_IN) begin
                port_rd_data_o = irq_in_q;
            end
        end
    end

endmodule

`default_nettype wire

// ==== praxos_bus_pkg.sv ====
`default_nettype none

package praxos_bus_pkg;

    // Pipelined Wishbone, master to slave
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        praxos_isa_pkg::port_addr_t adr;
        praxos_isa_pkg::word_t      dat_w;
        logic [3:0]                 sel;
    } wb_req_t;

    // Pipelined Wishbone, slave to master
    typedef struct packed {
        praxos_isa_pkg::word_t dat_r;
        logic                  ack;
        logic                  stall;
        logic                  err;
    } wb_rsp_t;

    // Core port I/O request, strobes last one cycle
    typedef struct packed {
        logic                       rd;
        logic                       wr;
        praxos_isa_pkg::port_addr_t addr;
        praxos_isa_pkg::word_t      wr_data;
    } port_req_t;

    // Program memory write
    typedef struct packed {
        logic                     wr;
        praxos_isa_pkg::pm_addr_t addr;
        praxos_isa_pkg::instr_t   data;
    } pm_wr_t;

endpackage

`default_nettype wire

// ==== praxos_isa_pkg.sv ====
`default_nettype none
`include "praxos_defs.svh"

package praxos_isa_pkg;

    typedef logic [`PRAXOS_WORD_W-1:0]  word_t;
    typedef logic [`PRAXOS_INSTR_W-1:0] instr_t;
    typedef logic [`PRAXOS_PM_AW-1:0]   pm_addr_t;
    typedef logic [`PRAXOS_PORT_AW-1:0] port_addr_t;
    typedef logic [`PRAXOS_IMM_W-1:0]   imm_t;

    // Codes 8 to 15 are free and decode as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_ADDI = 4'h2,
        OP_IN   = 4'h3,
        OP_OUT  = 4'h4,
        OP_JMP  = 4'h5,
        OP_JNZ  = 4'h6,
        OP_HALT = 4'h7
    } opcode_e;

    // Field view of instr_t
    typedef struct packed {
        opcode_e    op;
        port_addr_t port;
        imm_t       imm;
    } instr_fields_t;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_HALTED
    } core_state_e;

endpackage

`default_nettype wire

// ==== praxos_defs.svh ====
`ifndef PRAXOS_DEFS_SVH
`define PRAXOS_DEFS_SVH

// Program memory
`define PRAXOS_PM_DEPTH     256
`define PRAXOS_PM_AW        8

// Data path and instruction widths
`define PRAXOS_WORD_W       32
`define PRAXOS_INSTR_W      36
`define PRAXOS_IMM_W        26
`define PRAXOS_PORT_AW      6

// Register map, same addresses on the Wishbone and port sides
`define PRAXOS_REG_IRQ      6'd0
`define PRAXOS_REG_IRQ_IN   6'd1
`define PRAXOS_REG_PM_LO    6'd2
`define PRAXOS_REG_PM_HI    6'd3
`define PRAXOS_REG_PM_ADDR  6'd4
`define PRAXOS_REG_CTRL     6'd5
`define PRAXOS_REG_GP_BASE  6'd16
`define PRAXOS_GP_NUM       16

`endif
